/* build.f */
game_pkg.sv
key_decoder.sv
contact_detector.sv
player_motion.sv
level_progress.sv
game_top.sv
tb_game_top.sv

/* Bender.yml */
package:
  name: game_core

sources:
  - game_pkg.sv
  - key_decoder.sv
  - contact_detector.sv
  - player_motion.sv
  - level_progress.sv
  - game_top.sv
  - target: test
    files:
      - tb_game_top.sv

/* tb_game_top.sv */
`timescale 1ns/10ps

module tb_game_top
    import game_pkg::*;
();

    localparam int MOVE_DIV   = 2;
    localparam int WIN_BLOCKS = 4;

    // bottom edge of block 22 is the ceiling above the start position
    localparam int CEIL_Y  = 310 + 25;
    // first x where the player box overlaps flake 0 at x 50
    localparam int FLAKE_X = 50 - 24 + 1;
    // first x where the player box reaches over block 3 at x 75
    localparam int WIN_X   = 75 - 24 + 1;

    logic        clk;
    logic        rst_i;
    key_event_t  key_i;
    pos_t        pos_o;
    logic        airborne_o;
    game_state_e state_o;
    logic [3:0]  score_o;
    logic [5:0]  iced_count_o;

    int     errors = 0;
    int     timeouts = 0;
    integer seed = 32'hb8dd_0150;

    logic       track_steps;
    logic [9:0] x_prev;
    logic [8:0] y_prev;
    logic       won_prev;

    game_top #(
        .MOVE_DIV   (MOVE_DIV),
        .WIN_BLOCKS (WIN_BLOCKS)
    ) uut (
        .clk          (clk),
        .rst_i        (rst_i),
        .key_i        (key_i),
        .pos_o        (pos_o),
        .airborne_o   (airborne_o),
        .state_o      (state_o),
        .score_o      (score_o),
        .iced_count_o (iced_count_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        x_prev   <= pos_o.x;
        y_prev   <= pos_o.y;
        won_prev <= (state_o == WON);
    end

    // the player moves at most one pixel per clock in each direction
    a_single_step: assert property (
        @(posedge clk) disable iff (rst_i || !track_steps)
        (pos_o.x == x_prev || pos_o.x == x_prev + 10'd1) &&
        (pos_o.y == y_prev || pos_o.y == y_prev + 9'd1 || pos_o.y + 9'd1 == y_prev)
    ) else begin
        errors++;
        $display("Error: pos_o stepped from %h,%h to %h,%h", $sampled(x_prev),
                 $sampled(y_prev), $sampled(pos_o.x), $sampled(pos_o.y));
    end

    // flake 0 is the only one in reach of this run
    a_score_needs_flake: assert property (
        @(posedge clk) disable iff (rst_i)
        (score_o != 4'd0) |-> (pos_o.x >= 10'(FLAKE_X))
    ) else begin
        errors++;
        $display("Error: score_o is %h at pos_o.x %h", $sampled(score_o), $sampled(pos_o.x));
    end

    a_won_frozen: assert property (
        @(posedge clk) disable iff (rst_i)
        (state_o == WON && won_prev) |-> (pos_o.x == x_prev && pos_o.y == y_prev)
    ) else begin
        errors++;
        $display("Error: pos_o moved from %h,%h to %h,%h after the win", $sampled(x_prev),
                 $sampled(y_prev), $sampled(pos_o.x), $sampled(pos_o.y));
    end

    task automatic step_clocks(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_event(input logic [7:0] code, input logic released);
        key_i = '{valid: 1'b1, code: code, released: released};
        step_clocks(1);
        key_i = '0;
    endtask

    task automatic press_key(input logic [7:0] code);
        send_event(code, 1'b0);
    endtask

    task automatic release_key(input logic [7:0] code);
        send_event(code, 1'b1);
    endtask

    task automatic expect_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic expect_range(input string name, input int got, input int lo, input int hi);
        assert (got >= lo && got <= hi) else begin
            errors++;
            $display("Error: %s is %h, expected %h to %h", name, got, lo, hi);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
    endtask

    initial begin
        int cnt;
        int min_y;
        int hold_ticks;
        int x_won;

        rst_i       = 1'b1;
        key_i       = '0;
        track_steps = 1'b0;
        step_clocks(2);
        rst_i = 1'b0;

        expect_value("pos_o.x", pos_o.x, START_X);
        expect_value("pos_o.y", pos_o.y, START_Y);
        expect_value("airborne_o", airborne_o, 0);
        expect_value("state_o", state_o, PLAYING);
        expect_value("score_o", score_o, 0);
        expect_value("iced_count_o", iced_count_o, 0);

        // block 0 under the start position gets iced
        cnt = 0;
        while (iced_count_o != 6'd1 && cnt < 10) begin
            step_clocks(1);
            cnt++;
        end
        if (iced_count_o != 6'd1) note_timeout("block 0 to be iced");

        // left bound at x 0
        hold_ticks = 2 + ($unsigned($random(seed)) % 7);
        press_key(KEY_A);
        for (int i = 0; i < hold_ticks * MOVE_DIV; i++) begin
            step_clocks(1);
            expect_value("pos_o.x", pos_o.x, 0);
        end
        release_key(KEY_A);

        // jump into block 22 and fall back to the floor
        track_steps = 1'b1;
        press_key(KEY_W);
        cnt = 0;
        while (pos_o.y >= 9'(START_Y) && cnt < 200) begin
            step_clocks(1);
            cnt++;
        end
        if (pos_o.y >= 9'(START_Y)) note_timeout("the jump to start");
        release_key(KEY_W);
        cnt = 0;
        while (!airborne_o && cnt < 20) begin
            step_clocks(1);
            cnt++;
        end
        if (!airborne_o) note_timeout("airborne_o to rise");
        min_y = pos_o.y;
        cnt   = 0;
        while (pos_o.y != 9'(START_Y) && cnt < 20000) begin
            step_clocks(1);
            cnt++;
            if (pos_o.y < min_y) min_y = pos_o.y;
        end
        if (pos_o.y != 9'(START_Y)) note_timeout("the landing");
        expect_value("lowest pos_o.y", min_y, CEIL_Y);
        cnt = 0;
        while (airborne_o && cnt < 20) begin
            step_clocks(1);
            cnt++;
        end
        if (airborne_o) note_timeout("airborne_o to fall");

        // walk right, collect flake 0 and ice blocks 1 to 3
        press_key(KEY_D);
        cnt = 0;
        while (score_o != 4'd1 && cnt < 400) begin
            step_clocks(1);
            cnt++;
        end
        if (score_o != 4'd1) note_timeout("score_o to reach 1");
        // score lags the position by two registers or one tick here
        expect_range("pos_o.x", pos_o.x, FLAKE_X, FLAKE_X + 1);
        cnt = 0;
        while (state_o != WON && cnt < 400) begin
            step_clocks(1);
            cnt++;
        end
        if (state_o != WON) note_timeout("state_o to become WON");
        // contact, iced, count and state add four clocks
        expect_range("pos_o.x", pos_o.x, WIN_X, WIN_X + 2);
        expect_value("iced_count_o", iced_count_o, WIN_BLOCKS);
        step_clocks(1);
        x_won = pos_o.x;
        step_clocks(10 * MOVE_DIV);
        expect_value("pos_o.x", pos_o.x, x_won);
        expect_value("score_o", score_o, 1);
        release_key(KEY_D);
        track_steps = 1'b0;

        // restart
        press_key(KEY_R);
        release_key(KEY_R);
        cnt = 0;
        while ((pos_o.x != 10'(START_X) || pos_o.y != 9'(START_Y)) && cnt < 10) begin
            step_clocks(1);
            cnt++;
        end
        if (pos_o.x != 10'(START_X) || pos_o.y != 9'(START_Y)) note_timeout("the restart");
        expect_value("score_o", score_o, 0);
        expect_value("state_o", state_o, PLAYING);
        cnt = 0;
        while (iced_count_o != 6'd1 && cnt < 10) begin
            step_clocks(1);
            cnt++;
        end
        if (iced_count_o != 6'd1) note_timeout("block 0 to be iced again");
        expect_value("state_o", state_o, PLAYING);

        step_clocks(2);
        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* game_top.sv */
`timescale 1ns/10ps

module game_top
    import game_pkg::*;
#(
    parameter int MOVE_DIV   = 100000,
    parameter int WIN_BLOCKS = BLOCK_NUM
) (
    input  logic        clk,
    input  logic        rst_i,
    input  key_event_t  key_i,
    output pos_t        pos_o,
    output logic        airborne_o,
    output game_state_e state_o,
    output logic [3:0]  score_o,
    output logic [5:0]  iced_count_o
);

    held_keys_t           keys;
    logic                 restart;
    contact_t             contact;
    logic [BLOCK_NUM-1:0] stand_mask;

    key_decoder u_key_decoder (
        .clk       (clk),
        .rst_i     (rst_i),
        .key_i     (key_i),
        .keys_o    (keys),
        .restart_o (restart)
    );

    player_motion #(
        .MOVE_DIV (MOVE_DIV)
    ) u_player_motion (
        .clk        (clk),
        .rst_i      (rst_i),
        .keys_i     (keys),
        .restart_i  (restart),
        .contact_i  (contact),
        .state_i    (state_o),
        .pos_o      (pos_o),
        .airborne_o (airborne_o)
    );

    contact_detector u_contact_detector (
        .clk          (clk),
        .rst_i        (rst_i),
        .pos_i        (pos_o),
        .contact_o    (contact),
        .stand_mask_o (stand_mask)
    );

    level_progress #(
        .WIN_BLOCKS (WIN_BLOCKS)
    ) u_level_progress (
        .clk          (clk),
        .rst_i        (rst_i),
        .restart_i    (restart),
        .pos_i        (pos_o),
        .stand_mask_i (stand_mask),
        .state_o      (state_o),
        .score_o      (score_o),
        .iced_count_o (iced_count_o)
    );

endmodule

/* level_progress.sv */
`timescale 1ns/10ps

module level_progress
    import game_pkg::*;
#(
    parameter int WIN_BLOCKS = BLOCK_NUM
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 restart_i,
    input  pos_t                 pos_i,
    input  logic [BLOCK_NUM-1:0] stand_mask_i,
    output game_state_e          state_o,
    output logic [3:0]           score_o,
    output logic [5:0]           iced_count_o
);

    logic [BLOCK_NUM-1:0] iced;
    logic [FLAKE_NUM-1:0] collected;
    logic [FLAKE_NUM-1:0] flake_hit;
    logic                 restart_q;

    for (genvar f = 0; f < FLAKE_NUM; f++) begin : g_flake
        localparam pos_t FP = flake_pos(f);

        assign flake_hit[f] =
            spans_overlap(int'(pos_i.x), PLAYER_W, int'(FP.x), FLAKE_W) &&
            spans_overlap(int'(pos_i.y), PLAYER_H, int'(FP.y), FLAKE_H);
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            restart_q <= 1'b0;
        end else begin
            restart_q <= restart_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || restart_i) begin
            iced         <= '0;
            collected    <= '0;
            score_o      <= '0;
            iced_count_o <= '0;
            state_o      <= PLAYING;
        end else begin
            // mask still shows the old position right after restart
            if (!restart_q) begin
                iced <= iced | stand_mask_i;
            end
            collected    <= collected | flake_hit;
            score_o      <= 4'($countones(collected));
            iced_count_o <= 6'($countones(iced));
            if (iced_count_o >= 6'(WIN_BLOCKS)) begin
                state_o <= WON;
            end
        end
    end

    // collected flakes stay counted until restart
    a_score_monotonic: assert property (
        @(posedge clk) disable iff (rst_i)
        !restart_i |=> score_o >= $past(score_o)
    );

endmodule

/* player_motion.sv */
`timescale 1ns/10ps

module player_motion
    import game_pkg::*;
#(
    parameter int MOVE_DIV = 100000
) (
    input  logic        clk,
    input  logic        rst_i,
    input  held_keys_t  keys_i,
    input  logic        restart_i,
    input  contact_t    contact_i,
    input  game_state_e state_i,
    output pos_t        pos_o,
    output logic        airborne_o
);

    localparam int DIV_W = $clog2(MOVE_DIV + 1);

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic             move_en;
    logic [9:0]       pos_x;
    logic [8:0]       pos_y;
    logic             jumping;
    // ticks per vertical pixel, shared by rise and fall
    logic [5:0]       period;
    logic [5:0]       step_cnt;
    logic [4:0]       pix_cnt;
    logic             step_due;
    logic             pix_due;

    assign tick     = (div_cnt == DIV_W'(MOVE_DIV - 1));
    assign move_en  = tick && (state_i == PLAYING);
    assign step_due = (step_cnt == period - 6'd1);
    assign pix_due  = (pix_cnt == 5'(STEP_PIXELS - 1));
    assign pos_o    = '{x: pos_x, y: pos_y};

    // restart also realigns the tick so contact is fresh at the first move
    always_ff @(posedge clk) begin
        if (rst_i || restart_i || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || restart_i) begin
            pos_x <= 10'(START_X);
        end else if (move_en) begin
            if (keys_i.left && !keys_i.right && !contact_i.left && pos_x > 10'd0) begin
                pos_x <= pos_x - 10'd1;
            end else if (keys_i.right && !contact_i.right && pos_x < 10'(X_MAX)) begin
                pos_x <= pos_x + 10'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || restart_i) begin
            pos_y      <= 9'(START_Y);
            jumping    <= 1'b0;
            period     <= 6'(FALL_START);
            step_cnt   <= '0;
            pix_cnt    <= '0;
            airborne_o <= 1'b0;
        end else if (move_en) begin
            airborne_o <= !contact_i.down;
            if (jumping) begin
                if (contact_i.up || period >= 6'(JUMP_STOP)) begin
                    // head hit a block or the rise ran out of speed
                    jumping  <= 1'b0;
                    period   <= 6'(FALL_START);
                    step_cnt <= '0;
                    pix_cnt  <= '0;
                end else if (step_due) begin
                    pos_y    <= pos_y - 9'd1;
                    step_cnt <= '0;
                    pix_cnt  <= pix_due ? 5'd0 : pix_cnt + 5'd1;
                    // rise slows down as it goes
                    if (pix_due) begin
                        period <= period + 6'(SPEED_STEP);
                    end
                end else begin
                    step_cnt <= step_cnt + 6'd1;
                end
            end else if (keys_i.jump && contact_i.down) begin
                jumping  <= 1'b1;
                period   <= 6'(JUMP_START);
                step_cnt <= '0;
                pix_cnt  <= '0;
            end else if (!contact_i.down) begin
                if (step_due) begin
                    pos_y    <= pos_y + 9'd1;
                    step_cnt <= '0;
                    pix_cnt  <= pix_due ? 5'd0 : pix_cnt + 5'd1;
                    // fall speeds up until the period hits its floor
                    if (pix_due) begin
                        period <= (period >= 6'(FALL_MIN + SPEED_STEP)) ?
                                  period - 6'(SPEED_STEP) : 6'(FALL_MIN);
                    end
                end else begin
                    step_cnt <= step_cnt + 6'd1;
                end
            end else begin
                // standing, next fall starts slow again
                period   <= 6'(FALL_START);
                step_cnt <= '0;
                pix_cnt  <= '0;
            end
        end
    end

    a_x_in_bounds: assert property (
        @(posedge clk) disable iff (rst_i)
        pos_x <= 10'(X_MAX)
    );

endmodule

/* contact_detector.sv */
`timescale 1ns/10ps

module contact_detector
    import game_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    input  pos_t                 pos_i,
    output contact_t             contact_o,
    output logic [BLOCK_NUM-1:0] stand_mask_o
);

    int px;
    int py;
    logic [BLOCK_NUM-1:0] hit_down;
    logic [BLOCK_NUM-1:0] hit_up;
    logic [BLOCK_NUM-1:0] hit_right;
    logic [BLOCK_NUM-1:0] hit_left;

    assign px = int'(pos_i.x);
    assign py = int'(pos_i.y);

    // one comparator set per block with constant block corners
    for (genvar b = 0; b < BLOCK_NUM; b++) begin : g_block
        localparam pos_t BP = block_pos(b);
        localparam int BX = int'(BP.x);
        localparam int BY = int'(BP.y);

        logic x_ovl;
        logic y_ovl;

        assign x_ovl = spans_overlap(px, PLAYER_W, BX, BLOCK_W);
        assign y_ovl = spans_overlap(py, PLAYER_H, BY, BLOCK_H);

        // edges must touch exactly and a corner touch does not count
        assign hit_down[b]  = x_ovl && (py + PLAYER_H == BY);
        assign hit_up[b]    = x_ovl && (py == BY + BLOCK_H);
        assign hit_right[b] = y_ovl && (px + PLAYER_W == BX);
        assign hit_left[b]  = y_ovl && (px == BX + BLOCK_W);
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            contact_o    <= '0;
            stand_mask_o <= '0;
        end else begin
            contact_o.down  <= |hit_down;
            contact_o.up    <= |hit_up;
            contact_o.right <= |hit_right;
            contact_o.left  <= |hit_left;
            stand_mask_o    <= hit_down;
        end
    end

    // the player is narrower than a block and stands on two blocks at most
    a_stand_two_blocks: assert property (
        @(posedge clk) disable iff (rst_i)
        $countones(stand_mask_o) <= 2
    );

endmodule

/* key_decoder.sv */
`timescale 1ns/10ps

module key_decoder
    import game_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  key_event_t key_i,
    output held_keys_t keys_o,
    output logic       restart_o
);

    logic is_press;

    assign is_press = key_i.valid && !key_i.released;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            keys_o    <= '0;
            restart_o <= 1'b0;
        end else begin
            // single pulse per R make code
            restart_o <= is_press && (key_i.code == KEY_R);
            if (key_i.valid) begin
                // a break code only clears its own key
                case (key_i.code)
                    KEY_W: keys_o.jump <= !key_i.released;
                    KEY_A: keys_o.left <= !key_i.released;
                    KEY_D: keys_o.right <= !key_i.released;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* game_pkg.sv */
package game_pkg;

    typedef struct packed {
        logic       valid;
        logic [7:0] code;
        // break code, key went up
        logic       released;
    } key_event_t;

    typedef struct packed {
        logic jump;
        logic left;
        logic right;
    } held_keys_t;

    // down means the player's feet rest on a block top
    typedef struct packed {
        logic down;
        logic up;
        logic right;
        logic left;
    } contact_t;

    // top-left corner of the player box
    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
    } pos_t;

    typedef enum logic {
        PLAYING = 1'b0,
        WON     = 1'b1
    } game_state_e;

    // map geometry in pixels
    localparam int BLOCK_NUM = 50;
    localparam int FLAKE_NUM = 15;
    localparam int BLOCK_W   = 25;
    localparam int BLOCK_H   = 25;
    localparam int PLAYER_W  = 24;
    localparam int PLAYER_H  = 33;
    localparam int FLAKE_W   = 24;
    localparam int FLAKE_H   = 26;
    localparam int START_X   = 0;
    localparam int START_Y   = 367;
    localparam int X_MAX     = 540;

    // keyboard make codes
    localparam logic [7:0] KEY_W = 8'h1D;
    localparam logic [7:0] KEY_A = 8'h1C;
    localparam logic [7:0] KEY_D = 8'h23;
    localparam logic [7:0] KEY_R = 8'h2D;

    // vertical speed, periods in move ticks per pixel
    localparam int FALL_START  = 50;
    localparam int FALL_MIN    = 20;
    localparam int JUMP_START  = 25;
    localparam int JUMP_STOP   = 50;
    localparam int SPEED_STEP  = 5;
    localparam int STEP_PIXELS = 24;

    // true when [a0, a0+a_len) and [b0, b0+b_len) share at least one pixel
    function automatic logic spans_overlap(input int a0, input int a_len,
                                           input int b0, input int b_len);
        return (a0 < b0 + b_len) && (b0 < a0 + a_len);
    endfunction

    function automatic pos_t block_pos(input int i);
        pos_t p;
        if (i < 22) begin
            // floor row
            p.x = 10'(BLOCK_W * i);
            p.y = 9'd400;
        end else if (i < 27) begin
            p.x = 10'(BLOCK_W * (i - 22));
            p.y = 9'd310;
        end else if (i < 32) begin
            p.x = 10'(425 + BLOCK_W * (i - 27));
            p.y = 9'd310;
        end else if (i < 43) begin
            p.x = 10'(150 + BLOCK_W * (i - 32));
            p.y = 9'd225;
        end else begin
            p.x = 10'(BLOCK_W * (i - 43));
            p.y = 9'd135;
        end
        return p;
    endfunction

    function automatic pos_t flake_pos(input int i);
        pos_t p;
        if (i < 5) begin
            p.x = 10'(50 + 28 * i);
            p.y = 9'd370;
        end else if (i < 10) begin
            p.x = 10'(350 + 28 * (i - 5));
            p.y = 9'd370;
        end else begin
            p.x = 10'(28 * (i - 10));
            p.y = 9'd105;
        end
        return p;
    endfunction

endpackage
